// ==== design/ntm_fixed_pkg.sv ====
// Fixed-point number format shared by the NTM gate datapath
// Q8.8 operands, Q16.16 products and sums, term counts
// Breakpoints of the three-segment tanh approximation

package ntm_fixed_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Q8.8 operand width
  localparam int DATA_W = 16;
  // Q16.16 product and accumulator width
  localparam int ACC_W = 32;
  // Two accumulators plus bias need two guard bits
  localparam int SUM_W = ACC_W + 2;
  // Term and element counters
  localparam int SIZE_W = 8;

  // Fraction bits of the Q8.8 format
  localparam int FRAC_BITS = 8;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic signed [SUM_W-1:0]  sum_t;
  typedef logic        [SIZE_W-1:0] size_t;

  //////////////////////////////
  // Tanh breakpoints
  //////////////////////////////

  // 0.5 in Q16.16, end of the linear segment
  localparam acc_t TANH_KNEE_LO = 32'sh0000_8000;
  // 1.5 in Q16.16, start of saturation
  localparam acc_t TANH_KNEE_HI = 32'sh0001_8000;
  // 1.0 in Q8.8
  localparam data_t ONE_Q = 16'sh0100;

endpackage

// ==== design/ntm_gate_pkg.sv ====
// Gate combiner control definitions
// State encoding of the combiner FSM and vector size limits

package ntm_gate_pkg;

  //////////////////////////////
  // Combiner FSM
  //////////////////////////////

  // Idle until START, then loop collect/sum/activate per element
  typedef enum logic [1:0] {
    GATE_IDLE,
    GATE_COLLECT,
    GATE_SUM,
    GATE_ACTIVATE
  } gate_state_t;

  //////////////////////////////
  // Limits
  //////////////////////////////

  // Largest SIZE_L the element counter can express
  localparam int MAX_ELEMENTS = (1 << $bits(ntm_fixed_pkg::size_t)) - 1;

endpackage

// ==== design/ntm_dot_product.sv ====
// Streaming dot product engine
// Signed Q8.8 pairs multiplied to Q16.16 and accumulated over a runtime length

`timescale 1ns/100ps

module ntm_dot_product (
  input  logic                  CLK,
  input  logic                  RST,
  // Number of terms per result
  input  ntm_fixed_pkg::size_t  size,
  input  logic                  term_enable,
  input  ntm_fixed_pkg::data_t  op_a,
  input  ntm_fixed_pkg::data_t  op_b,
  output logic                  done,
  output ntm_fixed_pkg::acc_t   result
);

  import ntm_fixed_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Full-precision product of the current pair
  acc_t  product;
  // Running sum of the terms seen so far
  acc_t  acc;
  // Index of the current term
  size_t count;
  logic  last_term;

  //////////////////////////////
  // Multiply
  //////////////////////////////

  // Both operands signed, so they widen before the multiply
  assign product = op_a * op_b;

  // Last term of the element
  assign last_term = (count == size - 8'd1);

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc   <= '0;
      count <= '0;
      done  <= 1'b0;
    end else begin
      // Single-cycle done pulse
      done <= 1'b0;
      if (term_enable) begin
        if (last_term) begin
          // Clear for the next element, terms may follow at once
          acc   <= '0;
          count <= '0;
          done  <= 1'b1;
        end else begin
          acc   <= acc + product;
          count <= count + 8'd1;
        end
      end
    end
  end

  // Final sum, held until the next done
  always_ff @(posedge CLK) begin
    if (term_enable && last_term) begin
      result <= acc + product;
    end
  end

endmodule

// ==== design/ntm_tanh_unit.sv ====
// Registered piecewise-linear tanh
// Three segments on the magnitude, sign restored, Q16.16 in and Q8.8 out

`timescale 1ns/100ps

module ntm_tanh_unit (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  sum_valid,
  input  ntm_fixed_pkg::sum_t   sum_value,
  output logic                  act_valid,
  output ntm_fixed_pkg::data_t  act_value
);

  import ntm_fixed_pkg::*;

  logic neg;
  // Magnitude of the input
  sum_t mag;
  // Segment output before sign restore
  sum_t seg;
  sum_t act_q16;

  assign neg = sum_value[SUM_W-1];
  assign mag = neg ? -sum_value : sum_value;

  // Segment select on the magnitude
  always_comb begin
    if (mag < sum_t'(TANH_KNEE_LO)) begin
      // Linear region
      seg = mag;
    end else if (mag < sum_t'(TANH_KNEE_HI)) begin
      // Slope 1/2, offset 0.25
      seg = (mag >>> 1) + sum_t'(TANH_KNEE_LO >>> 1);
    end else begin
      // Saturated at 1.0
      seg = sum_t'(ONE_Q) <<< FRAC_BITS;
    end
  end

  // Odd function, so mirror for negative inputs
  assign act_q16 = neg ? -seg : seg;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      act_valid <= 1'b0;
    end else begin
      act_valid <= sum_valid;
    end
  end

  // Arithmetic shift rounds toward minus infinity
  always_ff @(posedge CLK) begin
    if (sum_valid) begin
      act_value <= data_t'(act_q16 >>> FRAC_BITS);
    end
  end

endmodule

// ==== design/ntm_gate_combiner.sv ====
// Gate combiner
// Collects W*x, U*h and bias per element, sums them and applies tanh
// Counts elements and flags the end of the vector

`timescale 1ns/100ps

module ntm_gate_combiner (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  START,
  input  ntm_fixed_pkg::size_t  size_l,
  input  logic                  x_done,
  input  ntm_fixed_pkg::acc_t   x_result,
  input  logic                  h_done,
  input  ntm_fixed_pkg::acc_t   h_result,
  input  logic                  bias_enable,
  input  ntm_fixed_pkg::data_t  bias,
  output ntm_fixed_pkg::data_t  A_OUT,
  output logic                  A_OUT_ENABLE,
  output logic                  READY
);

  import ntm_fixed_pkg::*;
  import ntm_gate_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  gate_state_t state;

  // Held parts of the current element
  logic  x_held, h_held, b_held;
  acc_t  x_q, h_q;
  data_t b_q;
  // Every part either held or arriving now
  logic  all_parts;

  // Element bookkeeping
  size_t size_q;
  size_t elem_count;
  logic  last_elem;
  // Element in the sum/tanh stages is the final one
  logic  sum_last;

  // Tanh stage
  logic  sum_valid;
  sum_t  sum_value;
  logic  act_valid;
  data_t act_value;

  assign all_parts = (x_held | x_done) & (h_held | h_done) & (b_held | bias_enable);
  assign last_elem = (elem_count == size_q - 8'd1);

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= GATE_IDLE;
      x_held     <= 1'b0;
      h_held     <= 1'b0;
      b_held     <= 1'b0;
      size_q     <= '0;
      elem_count <= '0;
      sum_last   <= 1'b0;
      sum_valid  <= 1'b0;
    end else begin
      sum_valid <= 1'b0;
      case (state)
        GATE_IDLE: begin
          if (START) begin
            size_q     <= size_l;
            elem_count <= '0;
            state      <= GATE_COLLECT;
          end
        end
        GATE_COLLECT: begin
          // Last part in, flags drop for the next element
          if (all_parts) begin
            x_held <= 1'b0;
            h_held <= 1'b0;
            b_held <= 1'b0;
            state  <= GATE_SUM;
          end else begin
            x_held <= x_held | x_done;
            h_held <= h_held | h_done;
            b_held <= b_held | bias_enable;
          end
        end
        GATE_SUM: begin
          sum_valid  <= 1'b1;
          sum_last   <= last_elem;
          elem_count <= elem_count + 8'd1;
          state      <= GATE_ACTIVATE;
        end
        default: begin
          // Tanh busy this cycle
          state <= sum_last ? GATE_IDLE : GATE_COLLECT;
        end
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Part capture
  always_ff @(posedge CLK) begin
    if (state == GATE_COLLECT) begin
      if (x_done) begin
        x_q <= x_result;
      end
      if (h_done) begin
        h_q <= h_result;
      end
      if (bias_enable) begin
        b_q <= bias;
      end
    end
  end

  // Bias aligned to Q16.16 before the add
  always_ff @(posedge CLK) begin
    if (state == GATE_SUM) begin
      sum_value <= sum_t'(x_q) + sum_t'(h_q) + (sum_t'(b_q) <<< FRAC_BITS);
    end
  end

  ntm_tanh_unit tanh_unit (
    .CLK       (CLK),
    .RST       (RST),
    .sum_valid (sum_valid),
    .sum_value (sum_value),
    .act_valid (act_valid),
    .act_value (act_value)
  );

  // Output register, READY only with the last element
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      A_OUT        <= '0;
      A_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
    end else begin
      A_OUT_ENABLE <= act_valid;
      READY        <= act_valid & sum_last;
      if (act_valid) begin
        A_OUT <= act_value;
      end
    end
  end

endmodule

// ==== design/ntm_activation_gate_vector.sv ====
// Activation gate top level
// a(l) = tanh(W*x + U*h + b) with input and recurrent paths side by side

`timescale 1ns/100ps

module ntm_activation_gate_vector (
  // Global
  input  logic                  CLK,
  input  logic                  RST,

  // Control
  input  logic                  START,
  output logic                  READY,

  // Stream strobes
  input  logic                  X_IN_ENABLE,
  input  logic                  H_IN_ENABLE,
  input  logic                  B_IN_ENABLE,
  output logic                  A_OUT_ENABLE,

  // Sizes
  input  ntm_fixed_pkg::size_t  SIZE_X_IN,
  input  ntm_fixed_pkg::size_t  SIZE_L_IN,

  // Data
  input  ntm_fixed_pkg::data_t  W_IN,
  input  ntm_fixed_pkg::data_t  X_IN,
  input  ntm_fixed_pkg::data_t  U_IN,
  input  ntm_fixed_pkg::data_t  H_IN,
  input  ntm_fixed_pkg::data_t  B_IN,
  output ntm_fixed_pkg::data_t  A_OUT
);

  import ntm_fixed_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Input path W*x
  logic x_done;
  acc_t x_result;

  // Recurrent path U*h
  logic h_done;
  acc_t h_result;

  //////////////////////////////
  // Dot products
  //////////////////////////////

  // SIZE_X_IN terms per element
  ntm_dot_product dot_x (
    .CLK         (CLK),
    .RST         (RST),
    .size        (SIZE_X_IN),
    .term_enable (X_IN_ENABLE),
    .op_a        (W_IN),
    .op_b        (X_IN),
    .done        (x_done),
    .result      (x_result)
  );

  // Square U, so SIZE_L_IN terms per element
  ntm_dot_product dot_h (
    .CLK         (CLK),
    .RST         (RST),
    .size        (SIZE_L_IN),
    .term_enable (H_IN_ENABLE),
    .op_a        (U_IN),
    .op_b        (H_IN),
    .done        (h_done),
    .result      (h_result)
  );

  //////////////////////////////
  // Combine and activate
  //////////////////////////////

  ntm_gate_combiner combiner (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .size_l       (SIZE_L_IN),
    .x_done       (x_done),
    .x_result     (x_result),
    .h_done       (h_done),
    .h_result     (h_result),
    .bias_enable  (B_IN_ENABLE),
    .bias         (B_IN),
    .A_OUT        (A_OUT),
    .A_OUT_ENABLE (A_OUT_ENABLE),
    .READY        (READY)
  );

endmodule

// ==== sim/ntm_gate_assert.sv ====
// Protocol checks for the gate combiner
// Output timing, READY qualification, part arrival, reset values

`timescale 1ns/100ps

module ntm_gate_assert (
  input logic                       CLK,
  input logic                       RST,
  input logic                       start,
  input ntm_fixed_pkg::size_t       size_l,
  input ntm_gate_pkg::gate_state_t  state,
  input logic                       x_done,
  input logic                       h_done,
  input logic                       bias_enable,
  input logic                       x_held,
  input logic                       h_held,
  input logic                       b_held,
  input logic                       a_out_enable,
  input logic                       ready
);

  import ntm_gate_pkg::*;

  // Output two cycles after the sum stage ends
  sum_to_output: assert property (@(posedge CLK) disable iff (RST)
    (state == GATE_SUM) |-> ##3 a_out_enable)
    else $error("A_OUT_ENABLE missing after GATE_SUM");

  ready_with_output: assert property (@(posedge CLK) disable iff (RST)
    ready |-> a_out_enable)
    else $error("READY without A_OUT_ENABLE");

  // No second copy of a held part
  x_not_twice: assert property (@(posedge CLK) disable iff (RST) x_done |-> !x_held)
    else $error("dot_x result arrived while held");
  h_not_twice: assert property (@(posedge CLK) disable iff (RST) h_done |-> !h_held)
    else $error("dot_h result arrived while held");
  b_not_twice: assert property (@(posedge CLK) disable iff (RST) bias_enable |-> !b_held)
    else $error("bias arrived while held");

  // Parts of the next element wait for the previous output
  part_in_collect: assert property (@(posedge CLK) disable iff (RST)
    (x_done || h_done || bias_enable) |-> (state == GATE_COLLECT))
    else $error("part arrived outside GATE_COLLECT");

  // A vector holds at least one element
  start_size: assert property (@(posedge CLK) disable iff (RST)
    (start && state == GATE_IDLE) |-> (size_l != 0))
    else $error("START with an element count of zero");

  quiet_in_reset: assert property (@(posedge CLK) RST |-> (!a_out_enable && !ready))
    else $error("outputs active during reset");

endmodule

// ==== sim/ntm_gate_tb.sv ====
// Testbench for the NTM activation gate
// Directed vector tests, fixed-point reference model, compare tasks, timeout

`timescale 1ns/100ps

module ntm_gate_tb;

  import ntm_fixed_pkg::*;

  // Longest test is 8 elements of 16 terms, far below this
  localparam int MAX_CYCLES = 4000;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic  CLK;
  logic  RST;
  logic  START;
  logic  READY;
  logic  X_IN_ENABLE;
  logic  H_IN_ENABLE;
  logic  B_IN_ENABLE;
  logic  A_OUT_ENABLE;
  size_t SIZE_X_IN;
  size_t SIZE_L_IN;
  data_t W_IN;
  data_t X_IN;
  data_t U_IN;
  data_t H_IN;
  data_t B_IN;
  data_t A_OUT;

  // Operands per element and term
  data_t w_mem [8][16];
  data_t x_mem [8][16];
  data_t u_mem [8][16];
  data_t h_mem [8][16];
  data_t b_mem [8];
  // Edge that sampled the last part of each element
  int    part_edge [8];

  int cycle = 0;
  int seed;
  int checks;
  int errors;
  int test_errors;

  ntm_activation_gate_vector ntm_activation_gate_vector_inst (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .X_IN_ENABLE  (X_IN_ENABLE),
    .H_IN_ENABLE  (H_IN_ENABLE),
    .B_IN_ENABLE  (B_IN_ENABLE),
    .A_OUT_ENABLE (A_OUT_ENABLE),
    .SIZE_X_IN    (SIZE_X_IN),
    .SIZE_L_IN    (SIZE_L_IN),
    .W_IN         (W_IN),
    .X_IN         (X_IN),
    .U_IN         (U_IN),
    .H_IN         (H_IN),
    .B_IN         (B_IN),
    .A_OUT        (A_OUT)
  );

  bind ntm_gate_combiner ntm_gate_assert combiner_assert (
    .CLK          (CLK),
    .RST          (RST),
    .start        (START),
    .size_l       (size_l),
    .state        (state),
    .x_done       (x_done),
    .h_done       (h_done),
    .bias_enable  (bias_enable),
    .x_held       (x_held),
    .h_held       (h_held),
    .b_held       (b_held),
    .a_out_enable (A_OUT_ENABLE),
    .ready        (READY)
  );

  //////////////////////////////
  // Clock and timeout
  //////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycle);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_data(string test, string what, data_t expected, data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test, what, expected, actual);
    end
  endtask

  task automatic check_flag(string test, string what, logic expected, logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", test, what, expected, actual);
    end
  endtask

  // Cycle counts, e.g. part-to-output latency
  task automatic check_count(string test, string what, size_t expected, size_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test, what, expected, actual);
    end
  endtask

  task automatic report_test(string name);
    $display("test %s: %0d errors", name, test_errors);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // tanh(W.x + U.h + b) of one element, Q16.16 sum, Q8.8 result
  function automatic data_t expected_gate(int l, int sx, int sl);
    longint s;
    longint m;
    longint seg;
    s = longint'(b_mem[l]) * 256;
    for (int k = 0; k < sx; k++) begin
      s += longint'(w_mem[l][k]) * longint'(x_mem[l][k]);
    end
    for (int k = 0; k < sl; k++) begin
      s += longint'(u_mem[l][k]) * longint'(h_mem[l][k]);
    end
    m = (s < 0) ? -s : s;
    // Knees at 0.5 and 1.5
    if (m < (64'sd1 <<< 15)) begin
      seg = m;
    end else if (m < (64'sd3 <<< 15)) begin
      seg = m / 2 + (64'sd1 <<< 14);
    end else begin
      seg = 64'sd1 <<< 16;
    end
    if (s < 0) begin
      seg = -seg;
    end
    // Floor to Q8.8
    return data_t'(seg >>> 8);
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Weights of 1.0, one nonzero term per path
  task automatic set_element(int l, data_t xv, data_t hv, data_t bv);
    for (int k = 0; k < 16; k++) begin
      w_mem[l][k] = ONE_Q;
      x_mem[l][k] = (k == 0) ? xv : '0;
      u_mem[l][k] = ONE_Q;
      h_mem[l][k] = (k == 0) ? hv : '0;
    end
    b_mem[l] = bv;
  endtask

  // Magnitude below 0.25
  function automatic data_t short_random();
    return data_t'($random(seed) % 64);
  endfunction

  task automatic set_random_element(int l);
    for (int k = 0; k < 16; k++) begin
      w_mem[l][k] = short_random();
      x_mem[l][k] = short_random();
      u_mem[l][k] = short_random();
      h_mem[l][k] = short_random();
    end
    b_mem[l] = short_random();
  endtask

  task automatic clear_strobes();
    @(posedge CLK);
    X_IN_ENABLE <= 1'b0;
    H_IN_ENABLE <= 1'b0;
    B_IN_ENABLE <= 1'b0;
  endtask

  // X and H streams from the same edge, bias at offset bo
  task automatic stream_element(int l, int sx, int sl, int bo);
    int len;
    len = (sx > sl) ? sx : sl;
    if (bo + 1 > len) begin
      len = bo + 1;
    end
    part_edge[l] = 0;
    for (int k = 0; k < len; k++) begin
      @(posedge CLK);
      X_IN_ENABLE <= (k < sx);
      W_IN        <= w_mem[l][k];
      X_IN        <= x_mem[l][k];
      H_IN_ENABLE <= (k < sl);
      U_IN        <= u_mem[l][k];
      H_IN        <= h_mem[l][k];
      B_IN_ENABLE <= (k == bo);
      B_IN        <= b_mem[l];
      // Strobe sampled at cycle + 2, done pulse seen one edge later
      if (k == sx - 1 && cycle + 3 > part_edge[l]) begin
        part_edge[l] = cycle + 3;
      end
      if (k == sl - 1 && cycle + 3 > part_edge[l]) begin
        part_edge[l] = cycle + 3;
      end
      if (k == bo && cycle + 2 > part_edge[l]) begin
        part_edge[l] = cycle + 2;
      end
    end
  endtask

  // One vector of sl elements, outputs checked as they arrive
  task automatic run_vector(string name, int sx, int sl, int bo, bit overlap);
    int got;
    got = 0;
    test_errors = 0;
    @(posedge CLK);
    SIZE_X_IN <= size_t'(sx);
    SIZE_L_IN <= size_t'(sl);
    START     <= 1'b1;
    @(posedge CLK);
    START     <= 1'b0;
    fork
      begin
        for (int l = 0; l < sl; l++) begin
          // Without overlap the next element waits for the previous output
          if (!overlap) begin
            wait (got == l);
          end
          stream_element(l, sx, sl, bo);
          if (!overlap || l == sl - 1) begin
            clear_strobes();
          end
        end
      end
      begin
        while (got < sl) begin
          @(negedge CLK);
          if (A_OUT_ENABLE) begin
            check_data(name, "A_OUT", expected_gate(got, sx, sl), A_OUT);
            check_flag(name, "READY", got == sl - 1, READY);
            check_count(name, "latency", 8'd3, size_t'(cycle - part_edge[got]));
            got++;
          end else begin
            check_flag(name, "READY between outputs", 1'b0, READY);
          end
        end
      end
    join
    report_test(name);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_test();
    test_errors = 0;
    repeat (20) begin
      @(negedge CLK);
      check_flag("reset", "A_OUT_ENABLE", 1'b0, A_OUT_ENABLE);
      check_flag("reset", "READY", 1'b0, READY);
      check_data("reset", "A_OUT", '0, A_OUT);
    end
    report_test("reset");
  endtask

  task automatic linear_test();
    // 0.125 + 0.0625 + 0.03125
    set_element(0, 16'sh0020, 16'sh0010, 16'sh0008);
    run_vector("linear", 1, 1, 0, 1'b0);
  endtask

  task automatic saturation_test();
    set_element(0, ONE_Q, 16'sh0080, 16'sh0080);
    set_element(1, -ONE_Q, -16'sh0080, -16'sh0040);
    run_vector("saturation", 1, 2, 0, 1'b0);
  endtask

  // Each run makes a different part arrive last
  task automatic middle_test();
    set_element(0, 16'sh0040, 16'sh0040, 16'sh0040);
    set_element(1, -16'sh0080, -16'sh0020, -16'sh0020);
    run_vector("middle x last", 4, 2, 0, 1'b0);
    set_element(0, 16'sh0100, 16'sh0020, 16'sh0020);
    set_element(1, -16'sh0080, -16'sh0040, -16'sh0040);
    set_element(2, 16'sh0040, 16'sh0020, 16'sh0020);
    run_vector("middle h last", 1, 3, 0, 1'b0);
    set_element(0, -16'sh00A0, -16'sh0040, -16'sh0020);
    set_element(1, -16'sh0053, -16'sh0020, -16'sh0020);
    run_vector("middle bias last", 2, 2, 4, 1'b0);
  endtask

  task automatic full_vector_test();
    for (int l = 0; l < 8; l++) begin
      set_random_element(l);
    end
    run_vector("full vector", 16, 8, 0, 1'b0);
  endtask

  // Next element's terms land while the previous one sums and activates
  task automatic overlap_test();
    for (int l = 0; l < 4; l++) begin
      set_random_element(l);
    end
    run_vector("overlap", 4, 4, 3, 1'b1);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed        = 32'hec164d56;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    RST         <= 1'b1;
    START       <= 1'b0;
    X_IN_ENABLE <= 1'b0;
    H_IN_ENABLE <= 1'b0;
    B_IN_ENABLE <= 1'b0;
    SIZE_X_IN   <= '0;
    SIZE_L_IN   <= '0;
    W_IN        <= '0;
    X_IN        <= '0;
    U_IN        <= '0;
    H_IN        <= '0;
    B_IN        <= '0;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;

    reset_test();
    linear_test();
    saturation_test();
    middle_test();
    full_vector_test();
    overlap_test();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
design/ntm_fixed_pkg.sv
design/ntm_gate_pkg.sv
design/ntm_dot_product.sv
design/ntm_tanh_unit.sv
design/ntm_gate_combiner.sv
design/ntm_activation_gate_vector.sv
sim/ntm_gate_assert.sv
sim/ntm_gate_tb.sv

// ==== Bender.yml ====
package:
  name: ntm_activation_gate

sources:
  # Packages first, then leaf modules up to the top level
  - design/ntm_fixed_pkg.sv
  - design/ntm_gate_pkg.sv
  - design/ntm_dot_product.sv
  - design/ntm_tanh_unit.sv
  - design/ntm_gate_combiner.sv
  - design/ntm_activation_gate_vector.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/ntm_gate_assert.sv
      - sim/ntm_gate_tb.sv
